/* Makefile */
# Verilator build of the exec_core testbench
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = exec_core_tb
FILELIST  = exec_core.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* exec_core.f */
verilog/exu_pkg.sv
verilog/exu_decoder.sv
verilog/exu_regfile.sv
verilog/exu_alu.sv
verilog/exu_execute.sv
verilog/exec_core.sv
tests/exec_clock.sv
tests/exec_core_assert.sv
tests/exec_core_tb.sv

/* tests/exec_clock.sv */
//##################################################
// testbench clock, period 8
// reset high for the first 3 rising edges
//##################################################
module exec_clock (
	output logic clk_o,
	output logic reset_o
);
	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		// release on a falling edge, like the other inputs
		@(negedge clk_o);
		reset_o = 1'b0;
	end

	always #HALF_PERIOD clk_o = ~clk_o;

endmodule

/* tests/exec_core_assert.sv */
//##################################################
// protocol checks on the exec_core outputs
// bound into every exec_core instance
// all checks off while reset is high
//##################################################
module exec_core_assert (
	input logic              clk,
	input logic              reset_i,
	input logic              inst_valid_i,
	input logic              wb_valid_i,
	input exu_pkg::reg_idx_t wb_reg_i,
	input logic              branch_taken_i,
	input logic              illegal_i
);

	// x0 writes are dropped in decode
	wb_not_x0: assert property (@(posedge clk) disable iff (reset_i)
		wb_valid_i |-> (wb_reg_i != 5'd0))
		else $error("write-back reported for register x0");

	// an illegal instruction retires nothing
	wb_not_illegal: assert property (@(posedge clk) disable iff (reset_i)
		!(wb_valid_i && illegal_i))
		else $error("write-back and illegal flag high together");

	// every pulse comes from a strobe one cycle earlier
	pulse_after_strobe: assert property (@(posedge clk) disable iff (reset_i)
		(wb_valid_i || branch_taken_i || illegal_i) |-> $past(inst_valid_i))
		else $error("output pulse without a strobe one cycle before");

endmodule

bind exec_core exec_core_assert exec_core_assert_i (
	.clk            (clk),
	.reset_i        (reset_i),
	.inst_valid_i   (inst_valid_i),
	.wb_valid_i     (wb_valid_o),
	.wb_reg_i       (wb_reg_o),
	.branch_taken_i (branch_taken_o),
	.illegal_i      (illegal_o)
);

/* tests/exec_core_tb.sv */
//##################################################
// directed tests for exec_core
// inputs driven on the falling edge
// each result checked at the falling edge after issue
// pc only counts up, redirects are not followed
//##################################################
module exec_core_tb;
	import exu_pkg::*;

	// slots per test, sized for the watchdog
	localparam int RESET_STEPS = 5;
	localparam int IMM_STEPS   = 2 * 13;
	localparam int REG_STEPS   = 10 * 5;
	localparam int BR_STEPS    = 3 * 10;
	localparam int JUMP_STEPS  = 6;
	localparam int ZERO_STEPS  = 6;
	localparam int DRAIN_STEPS = 2;
	localparam int TOTAL_STEPS = RESET_STEPS + IMM_STEPS + REG_STEPS + BR_STEPS
		+ JUMP_STEPS + ZERO_STEPS + DRAIN_STEPS;

	logic            clk;
	logic            reset_i;
	logic            inst_valid_i;
	logic [XLEN-1:0] inst_i;
	logic [XLEN-1:0] pc_i;
	logic            wb_valid_o;
	reg_idx_t        wb_reg_o;
	logic [XLEN-1:0] wb_data_o;
	logic            branch_taken_o;
	logic [XLEN-1:0] branch_target_o;
	logic            illegal_o;

	// architectural state and the instruction in flight
	logic [XLEN-1:0] shadow [0:31];
	logic [XLEN-1:0] pc;
	logic            pend_valid;
	logic            pend_wb;
	reg_idx_t        pend_rd;
	logic [XLEN-1:0] pend_data;
	logic            pend_taken;
	logic [XLEN-1:0] pend_target;
	logic            pend_ill;
	int              seed = 32'h87258238;

	exec_clock clock_i (
		.clk_o   (clk),
		.reset_o (reset_i)
	);

	exec_core exec_core_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.wb_valid_o      (wb_valid_o),
		.wb_reg_o        (wb_reg_o),
		.wb_data_o       (wb_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_wb(input logic exp_valid, input reg_idx_t exp_rd,
			input logic [XLEN-1:0] exp_data);
		if (wb_valid_o !== exp_valid)
			report_mismatch("wb_valid_o", 32'(wb_valid_o), 32'(exp_valid));
		if (exp_valid && wb_reg_o !== exp_rd)
			report_mismatch("wb_reg_o", 32'(wb_reg_o), 32'(exp_rd));
		if (exp_valid && wb_data_o !== exp_data)
			report_mismatch("wb_data_o", wb_data_o, exp_data);
	endtask

	task automatic check_branch(input logic exp_taken, input logic [XLEN-1:0] exp_target);
		if (branch_taken_o !== exp_taken)
			report_mismatch("branch_taken_o", 32'(branch_taken_o), 32'(exp_taken));
		if (exp_taken && branch_target_o !== exp_target)
			report_mismatch("branch_target_o", branch_target_o, exp_target);
	endtask

	task automatic check_illegal(input logic exp_ill);
		if (illegal_o !== exp_ill)
			report_mismatch("illegal_o", 32'(illegal_o), 32'(exp_ill));
	endtask

	// outputs of the slot issued one falling edge earlier
	task automatic check_pending();
		if (pend_valid) begin
			check_wb(pend_wb, pend_rd, pend_data);
			check_branch(pend_taken, pend_target);
			check_illegal(pend_ill);
		end else begin
			check_wb(1'b0, 5'd0, '0);
			check_branch(1'b0, '0);
			check_illegal(1'b0);
		end
	endtask

	task automatic send(input logic [XLEN-1:0] inst, input logic wb, input reg_idx_t rd,
			input logic [XLEN-1:0] data, input logic taken, input logic [XLEN-1:0] target,
			input logic ill);
		@(negedge clk);
		check_pending();
		inst_valid_i = 1'b1;
		inst_i       = inst;
		pc_i         = pc;
		pend_valid   = 1'b1;
		pend_wb      = wb;
		pend_rd      = rd;
		pend_data    = data;
		pend_taken   = taken;
		pend_target  = target;
		pend_ill     = ill;
		// later instructions see the result at once
		if (wb)
			shadow[rd] = data;
		pc = pc + 4;
	endtask

	task automatic idle();
		@(negedge clk);
		check_pending();
		inst_valid_i = 1'b0;
		pend_valid   = 1'b0;
	endtask

	function automatic logic [XLEN-1:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I semantics of funct3, alt picks sub and sra
	function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				sa = $signed(a) >>> b[4:0];
				return alt ? sa : a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic ref_branch(input logic [2:0] f3, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// encoders, each issues one instruction with its expected result
	task automatic op_imm(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
			input logic [11:0] imm);
		logic [XLEN-1:0] res;
		res = ref_alu(f3, (f3 == 3'd5) && imm[10], shadow[rs1], sext12(imm));
		send({imm, rs1, f3, rd, OPC_OP_IMM}, rd != 5'd0, rd, res, 1'b0, '0, 1'b0);
	endtask

	task automatic op_reg(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
			input reg_idx_t rs1, input reg_idx_t rs2);
		logic [XLEN-1:0] res;
		res = ref_alu(f3, alt, shadow[rs1], shadow[rs2]);
		send({alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP},
			rd != 5'd0, rd, res, 1'b0, '0, 1'b0);
	endtask

	task automatic lui(input reg_idx_t rd, input logic [19:0] imm);
		send({imm, rd, OPC_LUI}, rd != 5'd0, rd, {imm, 12'b0}, 1'b0, '0, 1'b0);
	endtask

	task automatic auipc(input reg_idx_t rd, input logic [19:0] imm);
		send({imm, rd, OPC_AUIPC}, rd != 5'd0, rd, pc + {imm, 12'b0}, 1'b0, '0, 1'b0);
	endtask

	task automatic jal(input reg_idx_t rd, input logic [20:0] off);
		send({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL}, rd != 5'd0, rd,
			pc + 4, 1'b1, pc + {{11{off[20]}}, off}, 1'b0);
	endtask

	task automatic jalr(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		logic [XLEN-1:0] sum;
		sum = shadow[rs1] + sext12(imm);
		send({imm, rs1, 3'b000, rd, OPC_JALR}, rd != 5'd0, rd, pc + 4, 1'b1,
			{sum[XLEN-1:1], 1'b0}, 1'b0);
	endtask

	task automatic branch(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
			input logic [12:0] off);
		send({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH}, 1'b0, 5'd0,
			'0, ref_branch(f3, shadow[rs1], shadow[rs2]), pc + {{19{off[12]}}, off}, 1'b0);
	endtask

	// full 32-bit constant, lui then addi
	task automatic load_reg(input reg_idx_t rd, input logic [XLEN-1:0] value);
		logic [XLEN-1:0] hi;
		hi = value + 32'h800;
		lui(rd, hi[31:12]);
		op_imm(3'd0, rd, rd, value[11:0]);
	endtask

	task automatic test_reset_idle();
		logic [XLEN-1:0] r;
		repeat (RESET_STEPS - 1) idle();
		r = rand32();
		// x6 never written, so the sum is the immediate
		op_imm(3'd0, 5'd5, 5'd6, r[11:0]);
	endtask

	task automatic test_op_imm();
		logic [XLEN-1:0] r;
		for (int round = 0; round < IMM_STEPS / 13; round++) begin
			load_reg(5'd1, rand32());
			for (int f = 0; f < 8; f++) begin
				r = rand32();
				if (f != 1 && f != 5)
					op_imm(3'(f), 5'd2, 5'd1, r[11:0]);
			end
			r = rand32();
			op_imm(3'd1, 5'd2, 5'd1, {7'b0000000, r[4:0]});
			op_imm(3'd5, 5'd2, 5'd1, {7'b0000000, r[9:5]});
			op_imm(3'd5, 5'd2, 5'd1, {7'b0100000, r[14:10]});
			lui(5'd3, r[31:12]);
			r = rand32();
			auipc(5'd4, r[19:0]);
		end
	endtask

	// ten ops, second operand always arrives through the bypass
	task automatic test_op_reg();
		logic [3:0] code;
		for (int c = 0; c < 16; c++) begin
			code = 4'(c);
			if (c < 9 || c == 13) begin
				load_reg(5'd1, rand32());
				load_reg(5'd2, rand32());
				op_reg(code[2:0], code[3], 5'd3, 5'd1, 5'd2);
			end
		end
	endtask

	task automatic test_branches();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] r;
		for (int p = 0; p < BR_STEPS / 10; p++) begin
			a = rand32();
			b = rand32();
			// equal, then signed-less, then unsigned-less
			if (p == 0)
				b = a;
			else if (p == 1) begin
				a = a | 32'h8000_0000;
				b = b & 32'h7fff_ffff;
			end else begin
				a = a & 32'h7fff_ffff;
				b = b | 32'h8000_0000;
			end
			load_reg(5'd6, a);
			load_reg(5'd7, b);
			for (int f = 0; f < 8; f++) begin
				r = rand32();
				if (f != 2 && f != 3)
					branch(3'(f), 5'd6, 5'd7, {r[12:1], 1'b0});
			end
		end
	endtask

	task automatic test_jumps();
		logic [XLEN-1:0] r;
		// odd base, even offset: bit 0 of the sum must be dropped
		load_reg(5'd8, rand32() | 32'h1);
		r = rand32();
		jal(5'd1, {r[20:1], 1'b0});
		r = rand32();
		jal(5'd0, {r[20:1], 1'b0});
		r = rand32();
		jalr(5'd9, 5'd8, {r[11:1], 1'b0});
		r = rand32();
		jalr(5'd8, 5'd8, {r[11:1], 1'b0});
	endtask

	task automatic test_zero_illegal();
		logic [XLEN-1:0] r;
		load_reg(5'd12, rand32());
		r = rand32();
		op_imm(3'd0, 5'd0, 5'd12, r[11:0]);
		op_reg(3'd0, 1'b0, 5'd11, 5'd0, 5'd0);
		// lw x12, imm(x1) is outside the kept groups
		send({r[23:12], 5'd1, 3'b010, 5'd12, 7'b0000011}, 1'b0, 5'd0, '0, 1'b0, '0, 1'b1);
		op_imm(3'd0, 5'd13, 5'd12, 12'd0);
	endtask

	initial begin
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		pc           = 32'h0000_2000;
		pend_valid   = 1'b0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		wait (reset_i === 1'b0);
		test_reset_idle();
		test_op_imm();
		test_op_reg();
		test_branches();
		test_jumps();
		test_zero_illegal();
		repeat (DRAIN_STEPS) idle();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// 20 cycles per slot plus reset
	initial begin
		repeat (20 * TOTAL_STEPS + 4) @(posedge clk);
		abort_run("timeout: the tests did not finish within the cycle budget");
	end

endmodule

/* verilog/exec_core.sv */
//##################################################
// execute cluster top, wiring only
// one instruction per cycle, no back-pressure
// registered write-back feeds the register file
//##################################################
module exec_core (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     inst_valid_i,
	input  logic [exu_pkg::XLEN-1:0] inst_i,
	input  logic [exu_pkg::XLEN-1:0] pc_i,
	output logic                     wb_valid_o,
	output exu_pkg::reg_idx_t        wb_reg_o,
	output logic [exu_pkg::XLEN-1:0] wb_data_o,
	output logic                     branch_taken_o,
	output logic [exu_pkg::XLEN-1:0] branch_target_o,
	output logic                     illegal_o
);
	import exu_pkg::*;

	reg_idx_t        rs1;
	reg_idx_t        rs2;
	reg_idx_t        rd;
	logic [XLEN-1:0] imm;
	alu_op_e         alu_op;
	src1_sel_e       src1_sel;
	src2_sel_e       src2_sel;
	branch_e         branch;
	logic            dec_wd;
	logic            dec_illegal;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;

	exu_decoder decoder_i (
		.inst_i     (inst_i),
		.rs1_o      (rs1),
		.rs2_o      (rs2),
		.rd_o       (rd),
		.imm_o      (imm),
		.alu_op_o   (alu_op),
		.src1_sel_o (src1_sel),
		.src2_sel_o (src2_sel),
		.branch_o   (branch),
		.wd_o       (dec_wd),
		.illegal_o  (dec_illegal)
	);

	// write port driven by the retiring instruction
	exu_regfile regfile_i (
		.clk      (clk),
		.reset_i  (reset_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.we_i     (wb_valid_o),
		.waddr_i  (wb_reg_o),
		.wdata_i  (wb_data_o),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	exu_execute execute_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.valid_i         (inst_valid_i),
		.pc_i            (pc_i),
		.reg1_i          (rdata1),
		.reg2_i          (rdata2),
		.imm_i           (imm),
		.alu_op_i        (alu_op),
		.src1_sel_i      (src1_sel),
		.src2_sel_i      (src2_sel),
		.branch_i        (branch),
		.wd_i            (dec_wd),
		.wreg_i          (rd),
		.illegal_i       (dec_illegal),
		.wd_o            (wb_valid_o),
		.wreg_o          (wb_reg_o),
		.wdata_o         (wb_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.illegal_o       (illegal_o)
	);

endmodule

/* verilog/exu_alu.sv */
//##################################################
// combinational alu
// flags always compare src1 against src2
// shifts use src2[4:0] only
//##################################################
module exu_alu (
	input  logic [exu_pkg::XLEN-1:0] src1_i,
	input  logic [exu_pkg::XLEN-1:0] src2_i,
	input  exu_pkg::alu_op_e         alu_op_i,
	output logic [exu_pkg::XLEN-1:0] result_o,
	output logic                     zero_o,
	output logic                     lt_o,
	output logic                     ltu_o
);
	import exu_pkg::*;

	// one extra bit keeps the borrow
	logic [XLEN:0] diff;
	logic [4:0]    shamt;

	assign diff  = {1'b0, src1_i} - {1'b0, src2_i};
	assign shamt = src2_i[4:0];

	// equal when the difference is zero
	assign zero_o = (diff[XLEN-1:0] == '0);
	// borrow out means src1 < src2 unsigned
	assign ltu_o  = diff[XLEN];
	// signs differ: the negative one is less
	// signs equal: no overflow, sign of the difference decides
	assign lt_o   = (src1_i[XLEN-1] != src2_i[XLEN-1]) ? src1_i[XLEN-1] : diff[XLEN-1];

	always_comb begin
		case (alu_op_i)
			ALU_ADD:  result_o = src1_i + src2_i;
			ALU_SUB:  result_o = diff[XLEN-1:0];
			ALU_SLL:  result_o = src1_i << shamt;
			ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_o};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, ltu_o};
			ALU_XOR:  result_o = src1_i ^ src2_i;
			ALU_SRL:  result_o = src1_i >> shamt;
			// arithmetic shift needs the signed view
			ALU_SRA:  result_o = $unsigned($signed(src1_i) >>> shamt);
			ALU_OR:   result_o = src1_i | src2_i;
			ALU_AND:  result_o = src1_i & src2_i;
			ALU_PASS: result_o = src2_i;
			default:  result_o = '0;
		endcase
	end

endmodule

/* verilog/exu_decoder.sv */
//##################################################
// purely combinational RV32I decode
// only OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH
// anything else raises illegal_o and writes nothing
//##################################################
module exu_decoder (
	input  logic [exu_pkg::XLEN-1:0] inst_i,
	output exu_pkg::reg_idx_t        rs1_o,
	output exu_pkg::reg_idx_t        rs2_o,
	output exu_pkg::reg_idx_t        rd_o,
	output logic [exu_pkg::XLEN-1:0] imm_o,
	output exu_pkg::alu_op_e         alu_op_o,
	output exu_pkg::src1_sel_e       src1_sel_o,
	output exu_pkg::src2_sel_e       src2_sel_o,
	output exu_pkg::branch_e         branch_o,
	output logic                     wd_o,
	output logic                     illegal_o
);
	import exu_pkg::*;

	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i_type;
	logic [XLEN-1:0] imm_u_type;
	logic [XLEN-1:0] imm_j_type;
	logic [XLEN-1:0] imm_b_type;
	logic            writes;

	// fixed field positions
	assign rs1_o  = inst_i[19:15];
	assign rs2_o  = inst_i[24:20];
	assign rd_o   = inst_i[11:7];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// sign-extended immediates
	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	always_comb begin
		imm_o      = imm_i_type;
		alu_op_o   = ALU_ADD;
		src1_sel_o = SRC1_ZERO;
		src2_sel_o = SRC2_REG2;
		branch_o   = BR_NONE;
		writes     = 1'b0;
		illegal_o  = 1'b0;
		case (opcode_e'(inst_i[6:0]))
			OPC_OP: begin
				src1_sel_o = SRC1_REG1;
				writes     = 1'b1;
				case (funct3)
					3'b000: alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
					3'b001: alu_op_o = ALU_SLL;
					3'b010: alu_op_o = ALU_SLT;
					3'b011: alu_op_o = ALU_SLTU;
					3'b100: alu_op_o = ALU_XOR;
					3'b101: alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
					3'b110: alu_op_o = ALU_OR;
					default: alu_op_o = ALU_AND;
				endcase
				// only bit 30 may be set, and only for sub and sra
				if ((funct7 & 7'b1011111) != 7'b0)
					illegal_o = 1'b1;
				if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
					illegal_o = 1'b1;
			end
			OPC_OP_IMM: begin
				src1_sel_o = SRC1_REG1;
				src2_sel_o = SRC2_IMM;
				writes     = 1'b1;
				case (funct3)
					3'b000: alu_op_o = ALU_ADD;
					3'b010: alu_op_o = ALU_SLT;
					3'b011: alu_op_o = ALU_SLTU;
					3'b100: alu_op_o = ALU_XOR;
					3'b110: alu_op_o = ALU_OR;
					3'b111: alu_op_o = ALU_AND;
					3'b001: begin
						alu_op_o  = ALU_SLL;
						illegal_o = (funct7 != 7'b0);
					end
					default: begin
						// srai keeps bit 30 in the imm, alu only takes shamt
						alu_op_o  = funct7[5] ? ALU_SRA : ALU_SRL;
						illegal_o = ((funct7 & 7'b1011111) != 7'b0);
					end
				endcase
			end
			OPC_LUI: begin
				imm_o      = imm_u_type;
				src2_sel_o = SRC2_IMM;
				alu_op_o   = ALU_PASS;
				writes     = 1'b1;
			end
			OPC_AUIPC: begin
				imm_o      = imm_u_type;
				src1_sel_o = SRC1_PC;
				src2_sel_o = SRC2_IMM;
				writes     = 1'b1;
			end
			OPC_JAL: begin
				// link value pc + 4 through the alu
				imm_o      = imm_j_type;
				src1_sel_o = SRC1_PC;
				src2_sel_o = SRC2_FOUR;
				branch_o   = BR_JAL;
				writes     = 1'b1;
			end
			OPC_JALR: begin
				src1_sel_o = SRC1_PC;
				src2_sel_o = SRC2_FOUR;
				writes     = 1'b1;
				if (funct3 != 3'b000)
					illegal_o = 1'b1;
				else
					branch_o = BR_JALR;
			end
			OPC_BRANCH: begin
				// compare on the sub path
				imm_o      = imm_b_type;
				src1_sel_o = SRC1_REG1;
				alu_op_o   = ALU_SUB;
				case (funct3)
					3'b000: branch_o = BR_BEQ;
					3'b001: branch_o = BR_BNE;
					3'b100: branch_o = BR_BLT;
					3'b101: branch_o = BR_BGE;
					3'b110: branch_o = BR_BLTU;
					3'b111: branch_o = BR_BGEU;
					default: illegal_o = 1'b1;
				endcase
			end
			default: illegal_o = 1'b1;
		endcase
	end

	// x0 never written, illegal never retires
	assign wd_o = writes && !illegal_o && (rd_o != 5'd0);

endmodule

/* verilog/exu_execute.sv */
//##################################################
// operand select, alu, branch resolve, one register stage
// outputs pulse one cycle after valid_i
// payload regs hold their value between pulses
//##################################################
module exu_execute (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     valid_i,
	input  logic [exu_pkg::XLEN-1:0] pc_i,
	input  logic [exu_pkg::XLEN-1:0] reg1_i,
	input  logic [exu_pkg::XLEN-1:0] reg2_i,
	input  logic [exu_pkg::XLEN-1:0] imm_i,
	input  exu_pkg::alu_op_e         alu_op_i,
	input  exu_pkg::src1_sel_e       src1_sel_i,
	input  exu_pkg::src2_sel_e       src2_sel_i,
	input  exu_pkg::branch_e         branch_i,
	input  logic                     wd_i,
	input  exu_pkg::reg_idx_t        wreg_i,
	input  logic                     illegal_i,
	output logic                     wd_o,
	output exu_pkg::reg_idx_t        wreg_o,
	output logic [exu_pkg::XLEN-1:0] wdata_o,
	output logic                     branch_taken_o,
	output logic [exu_pkg::XLEN-1:0] branch_target_o,
	output logic                     illegal_o
);
	import exu_pkg::*;

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic            alu_lt;
	logic            alu_ltu;
	logic            taken;
	logic [XLEN-1:0] target_base;
	logic [XLEN-1:0] target_sum;
	logic [XLEN-1:0] target;

	// source muxes
	always_comb begin
		case (src1_sel_i)
			SRC1_REG1: src1 = reg1_i;
			SRC1_PC:   src1 = pc_i;
			default:   src1 = '0;
		endcase
		case (src2_sel_i)
			SRC2_IMM:  src2 = imm_i;
			SRC2_FOUR: src2 = XLEN'(4);
			default:   src2 = reg2_i;
		endcase
	end

	exu_alu alu_i (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (alu_op_i),
		.result_o (alu_result),
		.zero_o   (alu_zero),
		.lt_o     (alu_lt),
		.ltu_o    (alu_ltu)
	);

	// branch condition from the alu flags
	always_comb begin
		case (branch_i)
			BR_BEQ:  taken = alu_zero;
			BR_BNE:  taken = !alu_zero;
			BR_BLT:  taken = alu_lt;
			BR_BGE:  taken = !alu_lt;
			BR_BLTU: taken = alu_ltu;
			BR_BGEU: taken = !alu_ltu;
			BR_JAL:  taken = 1'b1;
			BR_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// separate target adder, alu is busy with the compare or link
	assign target_base = (branch_i == BR_JALR) ? reg1_i : pc_i;
	assign target_sum  = target_base + imm_i;
	// jalr clears bit 0
	assign target      = (branch_i == BR_JALR) ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

	// strobes, cleared by reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			wd_o           <= 1'b0;
			branch_taken_o <= 1'b0;
			illegal_o      <= 1'b0;
		end else begin
			wd_o           <= valid_i && wd_i;
			branch_taken_o <= valid_i && taken;
			illegal_o      <= valid_i && illegal_i;
		end
	end

	// payload, loaded only with an instruction
	always_ff @(posedge clk) begin
		if (valid_i) begin
			wreg_o          <= wreg_i;
			wdata_o         <= alu_result;
			branch_target_o <= target;
		end
	end

endmodule

/* verilog/exu_pkg.sv */
//##################################################
// shared width and encodings of the execute cluster
// XLEN is fixed at 32 by the RV32 encodings
// alu, select and branch codes are internal only
//##################################################
package exu_pkg;

	// data and address width
	parameter int XLEN = 32;

	// architectural register index
	typedef logic [4:0] reg_idx_t;

	// major opcodes, inst[6:0]
	// loads, stores, fences and system ops are not decoded
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	// alu operations
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		// result is src2 unchanged
		ALU_PASS = 4'd10
	} alu_op_e;

	// first alu source
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2
	} src1_sel_e;

	// second alu source
	typedef enum logic [1:0] {
		SRC2_REG2 = 2'd0,
		SRC2_IMM  = 2'd1,
		SRC2_FOUR = 2'd2
	} src2_sel_e;

	// branch kind, nine values so four bits
	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_BEQ  = 4'd1,
		BR_BNE  = 4'd2,
		BR_BLT  = 4'd3,
		BR_BGE  = 4'd4,
		BR_BLTU = 4'd5,
		BR_BGEU = 4'd6,
		BR_JAL  = 4'd7,
		BR_JALR = 4'd8
	} branch_e;

endpackage

/* verilog/exu_regfile.sv */
//##################################################
// 31 registers, x0 reads as zero
// reads combinational, write lands on the edge
// same-cycle write is bypassed to the read ports
//##################################################
module exu_regfile (
	input  logic                     clk,
	input  logic                     reset_i,
	input  exu_pkg::reg_idx_t        rs1_i,
	input  exu_pkg::reg_idx_t        rs2_i,
	input  logic                     we_i,
	input  exu_pkg::reg_idx_t        waddr_i,
	input  logic [exu_pkg::XLEN-1:0] wdata_i,
	output logic [exu_pkg::XLEN-1:0] rdata1_o,
	output logic [exu_pkg::XLEN-1:0] rdata2_o
);
	import exu_pkg::*;

	logic [XLEN-1:0] regs [1:31];
	logic            wr_en;

	// writes to x0 dropped
	assign wr_en = we_i && (waddr_i != 5'd0);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// bypass: the retiring result wins over the stored value
	assign rdata1_o = (rs1_i == 5'd0) ? '0 :
		(wr_en && waddr_i == rs1_i) ? wdata_i : regs[rs1_i];
	assign rdata2_o = (rs2_i == 5'd0) ? '0 :
		(wr_en && waddr_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule
